// ==== source/cpu_pkg.sv ====
// RV32I subset core definitions
package cpu_pkg;

    localparam int XLEN     = 32;                   // data and address width
    localparam int REG_AW   = 5;                    // register index width
    localparam int ALU_OP_W = 4;                    // alu operation code width
    localparam int IMM_SL_W = 2;                    // immediate select width

    typedef logic [XLEN-1     : 0] word_t;          // data, instr or address word
    typedef logic [REG_AW-1   : 0] reg_addr_t;      // register index
    typedef logic [ALU_OP_W-1 : 0] alu_op_t;        // alu operation code
    typedef logic [IMM_SL_W-1 : 0] imm_sel_t;       // immediate format select

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SLT    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8;         // lui passes immediate through

    // immediate formats
    localparam imm_sel_t IMM_I = 2'd0;
    localparam imm_sel_t IMM_U = 2'd1;
    localparam imm_sel_t IMM_B = 2'd2;

    // major opcodes
    localparam logic [6 : 0] OP_R      = 7'b0110011;
    localparam logic [6 : 0] OP_I      = 7'b0010011;
    localparam logic [6 : 0] OP_LUI    = 7'b0110111;
    localparam logic [6 : 0] OP_BRANCH = 7'b1100011;

    // funct3 for alu ops
    localparam logic [2 : 0] F3_ADD = 3'b000;
    localparam logic [2 : 0] F3_SLL = 3'b001;
    localparam logic [2 : 0] F3_SLT = 3'b010;
    localparam logic [2 : 0] F3_XOR = 3'b100;
    localparam logic [2 : 0] F3_SRL = 3'b101;
    localparam logic [2 : 0] F3_OR  = 3'b110;
    localparam logic [2 : 0] F3_AND = 3'b111;
    // funct3 for branches
    localparam logic [2 : 0] F3_BEQ = 3'b000;
    localparam logic [2 : 0] F3_BNE = 3'b001;

    localparam logic [6 : 0] F7_SUB = 7'b0100000;  // funct7 of sub

    localparam word_t RESET_PC = 32'h0000_0000;    // first fetch address

    // control bundle from the decoder
    typedef struct packed {
        logic       reg_we;                         // register write enable
        logic       src_b_imm;                      // operand b from immediate
        logic       branch;                         // conditional branch
        logic       branch_ne;                      // bne, else beq
        imm_sel_t   imm_sel;                        // immediate format
        alu_op_t    alu_op;                         // alu operation
    } ctrl_t;

endpackage : cpu_pkg

// ==== source/cpu_pc_unit.sv ====
// Program counter and branch logic
module cpu_pc_unit
    import cpu_pkg::*;
(
    input   logic   clk,            // clock
    input   logic   rst,            // sync reset, active high
    input   logic   cpu_en,         // commit enable
    input   word_t  rd1,            // branch compare operand a
    input   word_t  rd2,            // branch compare operand b
    input   word_t  imm,            // b-immediate, not yet shifted
    input   logic   branch,         // branch instruction
    input   logic   branch_ne,      // bne when set
    output  word_t  pc              // current instruction address
);

    logic   ops_equal;              // rd1 == rd2
    logic   take_branch;            // branch condition met
    word_t  pc_plus4;               // sequential next pc
    word_t  pc_target;              // branch target
    word_t  pc_next;                // selected next pc

    assign ops_equal   = (rd1 == rd2);
    assign take_branch = branch & (branch_ne ? ~ops_equal : ops_equal);   // invert for bne

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + (imm << 1);     // b offsets are in halfwords
    assign pc_next   = take_branch ? pc_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (cpu_en) begin
            pc <= pc_next;              // hold while disabled
        end
    end

endmodule : cpu_pc_unit

// ==== source/cpu_reg_file.sv ====
// Register file with debug port
module cpu_reg_file
    import cpu_pkg::*;
(
    input   logic       clk,        // clock
    input   logic       rst,        // sync reset, active high
    input   logic       we,         // write enable, already gated by cpu_en
    input   reg_addr_t  ra1,        // read address 1
    input   reg_addr_t  ra2,        // read address 2
    input   reg_addr_t  wa3,        // write address
    input   reg_addr_t  ra0,        // debug read address
    input   word_t      wd3,        // write data
    output  word_t      rd1,        // read data 1
    output  word_t      rd2,        // read data 2
    output  word_t      rd0         // debug read data
);

    word_t  regs [1 : 31];          // x1..x31, x0 is not stored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa3 != '0)) begin
            regs[wa3] <= wd3;           // writes to x0 dropped
        end
    end

    // combinational reads, x0 reads zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
    assign rd0 = (ra0 == '0) ? '0 : regs[ra0];

endmodule : cpu_reg_file

// ==== source/cpu_alu.sv ====
// Integer ALU
module cpu_alu
    import cpu_pkg::*;
(
    input   word_t          src_a,      // operand a, from rd1
    input   word_t          src_b,      // operand b, rd2 or immediate
    input   logic   [4 : 0] shamt,      // shift amount
    input   alu_op_t        alu_op,     // operation select
    output  word_t          result      // operation result
);

    logic   lt_signed;                  // signed a < b

    assign lt_signed = ($signed(src_a) < $signed(src_b));

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = src_a + src_b;
            end
            ALU_SUB: begin
                result = src_a - src_b;
            end
            ALU_AND: begin
                result = src_a & src_b;
            end
            ALU_OR: begin
                result = src_a | src_b;
            end
            ALU_XOR: begin
                result = src_a ^ src_b;
            end
            ALU_SLL: begin
                result = src_a << shamt;        // logical left
            end
            ALU_SRL: begin
                result = src_a >> shamt;        // logical right, zero fill
            end
            ALU_SLT: begin
                result = {31'b0, lt_signed};    // 1 or 0
            end
            ALU_PASS_B: begin
                result = src_b;                 // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule : cpu_alu

// ==== source/cpu_imm_gen.sv ====
// Immediate generator
module cpu_imm_gen
    import cpu_pkg::*;
(
    input   word_t      instr,      // instruction word
    input   imm_sel_t   imm_sel,    // format select
    output  word_t      imm         // extended immediate
);

    word_t  imm_i;                  // i format, sign extended
    word_t  imm_u;                  // u format, low bits zero
    word_t  imm_b;                  // b format, sign extended, unshifted

    assign imm_i = {{20{instr[31]}}, instr[31 : 20]};
    assign imm_u = {instr[31 : 12], 12'b0};
    // b bits are scattered, bit 0 of the offset is implied
    assign imm_b = {{20{instr[31]}}, instr[31], instr[7], instr[30 : 25], instr[11 : 8]};

    always_comb begin
        case (imm_sel)
            IMM_I: begin
                imm = imm_i;
            end
            IMM_U: begin
                imm = imm_u;
            end
            IMM_B: begin
                imm = imm_b;
            end
            default: begin
                imm = '0;               // unused code
            end
        endcase
    end

endmodule : cpu_imm_gen

// ==== source/cpu_decoder.sv ====
// Instruction decoder
module cpu_decoder
    import cpu_pkg::*;
(
    input   logic   [6 : 0]     opcode,     // opcode field
    input   logic   [2 : 0]     funct3,     // funct3 field
    input   logic   [6 : 0]     funct7,     // funct7 field
    output  ctrl_t              ctrl        // control bundle
);

    // alu op shared by r-type and i-type
    function automatic alu_op_t f3_to_alu(input logic [2 : 0] f3);
        alu_op_t op;
        case (f3)
            F3_ADD: begin
                op = ALU_ADD;
            end
            F3_SLL: begin
                op = ALU_SLL;
            end
            F3_SLT: begin
                op = ALU_SLT;
            end
            F3_XOR: begin
                op = ALU_XOR;
            end
            F3_SRL: begin
                op = ALU_SRL;
            end
            F3_OR: begin
                op = ALU_OR;
            end
            F3_AND: begin
                op = ALU_AND;
            end
            default: begin
                op = ALU_ADD;       // sltu not supported
            end
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl         = '0;              // no write, no branch
        ctrl.imm_sel = IMM_I;
        ctrl.alu_op  = ALU_ADD;
        case (opcode)
            OP_R: begin
                ctrl.reg_we = 1'b1;
                if ((funct3 == F3_ADD) && (funct7 == F7_SUB)) begin
                    ctrl.alu_op = ALU_SUB;
                end else begin
                    ctrl.alu_op = f3_to_alu(funct3);
                end
            end
            OP_I: begin
                ctrl.reg_we    = 1'b1;
                ctrl.src_b_imm = 1'b1;  // also selects shamt field for slli/srli
                ctrl.imm_sel   = IMM_I;
                ctrl.alu_op    = f3_to_alu(funct3);
            end
            OP_LUI: begin
                ctrl.reg_we    = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm_sel   = IMM_U;
                ctrl.alu_op    = ALU_PASS_B;
            end
            OP_BRANCH: begin
                ctrl.imm_sel   = IMM_B;
                ctrl.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                ctrl.branch_ne = (funct3 == F3_BNE);
            end
            default: begin
                // unknown opcode, falls through as pc+4
            end
        endcase
    end

endmodule : cpu_decoder

// ==== source/cpu_core.sv ====
// Single-cycle RV32I subset core
module cpu_core
    import cpu_pkg::*;
(
    input   logic       clk,            // clock
    input   logic       rst,            // sync reset, active high
    input   logic       cpu_en,         // commit one instruction per edge
    output  word_t      instr_addr,     // instruction address
    input   word_t      instr,          // instruction word, same cycle
    input   reg_addr_t  reg_addr,       // debug register address
    output  word_t      reg_data        // debug register data
);

    // instruction fields
    logic   [6 : 0]     opcode;         // major opcode
    logic   [2 : 0]     funct3;         // funct3
    logic   [6 : 0]     funct7;         // funct7
    reg_addr_t          rs1;            // source register 1
    reg_addr_t          rs2;            // source register 2
    reg_addr_t          rd;             // destination register
    logic   [4 : 0]     shamt;          // immediate shift amount

    ctrl_t              ctrl;           // decoded control
    word_t              imm;            // extended immediate
    word_t              rd1;            // rs1 data
    word_t              rd2;            // rs2 data
    word_t              src_b;          // alu operand b
    logic   [4 : 0]     alu_shamt;      // shift amount to alu
    word_t              alu_result;     // writeback data
    logic               rf_we;          // gated write enable

    assign opcode = instr[6 : 0];
    assign rd     = instr[11 : 7];
    assign funct3 = instr[14 : 12];
    assign rs1    = instr[19 : 15];
    assign rs2    = instr[24 : 20];
    assign shamt  = instr[24 : 20];     // overlaps rs2 field
    assign funct7 = instr[31 : 25];

    assign src_b     = ctrl.src_b_imm ? imm : rd2;
    assign alu_shamt = ctrl.src_b_imm ? shamt : rd2[4 : 0];    // r-type uses low 5 bits of rs2
    assign rf_we     = ctrl.reg_we & cpu_en;                    // nothing commits while held

    cpu_decoder u_cpu_decoder (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .ctrl       (ctrl)
    );

    cpu_imm_gen u_cpu_imm_gen (
        .instr      (instr),
        .imm_sel    (ctrl.imm_sel),
        .imm        (imm)
    );

    cpu_reg_file u_cpu_reg_file (
        .clk        (clk),
        .rst        (rst),
        .we         (rf_we),
        .ra1        (rs1),
        .ra2        (rs2),
        .wa3        (rd),
        .ra0        (reg_addr),         // debug port
        .wd3        (alu_result),
        .rd1        (rd1),
        .rd2        (rd2),
        .rd0        (reg_data)
    );

    cpu_alu u_cpu_alu (
        .src_a      (rd1),
        .src_b      (src_b),
        .shamt      (alu_shamt),
        .alu_op     (ctrl.alu_op),
        .result     (alu_result)
    );

    cpu_pc_unit u_cpu_pc_unit (
        .clk        (clk),
        .rst        (rst),
        .cpu_en     (cpu_en),
        .rd1        (rd1),
        .rd2        (rd2),
        .imm        (imm),
        .branch     (ctrl.branch),
        .branch_ne  (ctrl.branch_ne),
        .pc         (instr_addr)        // pc drives fetch address directly
    );

endmodule : cpu_core

// ==== verif/cpu_ref_model.svh ====
// Reference model and instruction generator
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

word_t  lfsr_state;                     // fibonacci lfsr, x^32+x^22+x^2+x+1
word_t  model_pc;                       // expected instruction address
word_t  model_regs [0 : 31];            // expected register contents

// one lfsr step, the new bit is the output
function automatic logic lfsr_next();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30 : 0], fb};
    return fb;
endfunction

// n fresh bits, one step per bit
function automatic word_t random_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30 : 0], lfsr_next()};
    end
    return v;
endfunction

function automatic reg_addr_t random_reg();
    return reg_addr_t'(random_bits(3));     // x0..x7 only
endfunction

// one random word of the supported mix
function automatic word_t random_instr();
    logic [3 : 0]   kind;
    logic [2 : 0]   f3;
    logic [6 : 0]   f7;
    logic [11 : 0]  imm12;
    logic [12 : 0]  offset;
    logic [6 : 0]   opc;
    reg_addr_t      rd;
    reg_addr_t      rs1;
    reg_addr_t      rs2;
    word_t          upper;
    int             words;
    word_t          ins;
    kind = 4'(random_bits(4));
    rd   = random_reg();
    rs1  = random_reg();
    rs2  = random_reg();
    f3   = 3'(random_bits(3));
    if (f3 == 3'b011) begin
        f3 = 3'b000;                        // sltu is outside the subset
    end
    if (kind == 4'd0) begin
        // load, store, jal, auipc
        case (2'(random_bits(2)))
            2'd0:    opc = 7'b0000011;
            2'd1:    opc = 7'b0100011;
            2'd2:    opc = 7'b1101111;
            default: opc = 7'b0010111;
        endcase
        upper = random_bits(25);
        ins   = {upper[24 : 0], opc};
    end else if (kind <= 4'd5) begin
        f7 = 7'b0000000;
        if ((f3 == 3'b000) && lfsr_next()) begin
            f7 = 7'b0100000;                // sub
        end
        ins = {f7, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind <= 4'd10) begin
        imm12 = 12'(random_bits(12));
        if ((f3 == 3'b001) || (f3 == 3'b101)) begin
            imm12 = {7'b0, imm12[4 : 0]};   // slli, srli shamt only
        end
        ins = {imm12, rs1, f3, rd, 7'b0010011};
    end else if (kind <= 4'd12) begin
        upper = random_bits(20);
        ins   = {upper[19 : 0], rd, 7'b0110111};
    end else begin
        words = int'(random_bits(3)) + 1;   // 1..8 words
        if (random_bits(2) == '0) begin
            words = -words;                 // backward, one in four
        end
        offset = 13'(words * 4);
        f3     = {2'b00, f3[0]};            // beq or bne
        ins    = {offset[12], offset[10 : 5], rs2, rs1, f3,
                  offset[4 : 1], offset[11], 7'b1100011};
    end
    return ins;
endfunction

function automatic void model_reset();
    model_pc = RESET_PC;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

// commit one instruction, rv32i semantics
function automatic void model_execute(input word_t ins);
    logic [6 : 0]   opc;
    logic [2 : 0]   f3;
    word_t          a;
    word_t          b;
    word_t          res;
    word_t          next_pc;
    logic           wr;
    opc     = ins[6 : 0];
    f3      = ins[14 : 12];
    a       = model_regs[ins[19 : 15]];
    b       = model_regs[ins[24 : 20]];
    res     = '0;
    wr      = 1'b0;
    next_pc = model_pc + 32'd4;
    if (opc == 7'b0010011) begin
        b = {{20{ins[31]}}, ins[31 : 20]};  // i-type operand, low 5 bits are shamt
    end
    case (opc)
        7'b0110011, 7'b0010011: begin
            wr = 1'b1;
            case (f3)
                3'b000:  res = ((opc == 7'b0110011) && ins[30]) ? a - b : a + b;
                3'b001:  res = a << b[4 : 0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101:  res = a >> b[4 : 0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        7'b0110111: begin
            wr  = 1'b1;
            res = {ins[31 : 12], 12'h000};  // lui
        end
        7'b1100011: begin
            if (((f3 == 3'b000) && (a == b)) || ((f3 == 3'b001) && (a != b))) begin
                next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30 : 25],
                                      ins[11 : 8], 1'b0};
            end
        end
        default: begin
            // not in the subset, only pc+4
        end
    endcase
    if (wr && (ins[11 : 7] != 5'd0)) begin
        model_regs[ins[11 : 7]] = res;      // x0 stays zero
    end
    model_pc = next_pc;
endfunction

`endif

// ==== verif/cpu_tb.sv ====
// Single-cycle core testbench
module cpu_tb
    import cpu_pkg::*;
();

    localparam int      CLK_PERIOD = 10;
    localparam int      RST_CYCLES = 3;
    localparam int      NUM_CYCLES = 1000;
    localparam int      PROG_DEPTH = 64;
    localparam word_t   LFSR_SEED  = 32'd77072;
    localparam int      TIMEOUT    = (NUM_CYCLES + RST_CYCLES) * CLK_PERIOD * 3 / 2;

    logic       clk;
    logic       rst;
    logic       cpu_en;
    word_t      instr;
    word_t      instr_addr;
    reg_addr_t  reg_addr;
    word_t      reg_data;

    word_t      prog [0 : PROG_DEPTH-1];    // instruction memory
    int         sweep_idx;                  // debug port rotation, x0..x7

    `include "cpu_ref_model.svh"

    cpu_core u_cpu_core (
        .clk        (clk),
        .rst        (rst),
        .cpu_en     (cpu_en),
        .instr_addr (instr_addr),
        .instr      (instr),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the core test did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    task automatic check_pc(input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: instr_addr expected %h actual %h", expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input reg_addr_t addr, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: reg_data x%0d expected %h actual %h", addr, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // new inputs for the coming edge, model commits along
    task automatic drive_next();
        cpu_en    = (random_bits(2) != '0);             // high 3 of 4
        instr     = prog[(instr_addr >> 2) % PROG_DEPTH];
        reg_addr  = reg_addr_t'(sweep_idx);
        sweep_idx = (sweep_idx + 1) % 8;
        if (cpu_en) begin
            model_execute(prog[(model_pc >> 2) % PROG_DEPTH]);
        end
    endtask

    initial begin
        rst        = 1'b1;
        cpu_en     = 1'b0;
        instr      = '0;
        reg_addr   = '0;
        sweep_idx  = 0;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < PROG_DEPTH; i++) begin
            prog[i] = random_instr();
        end
        model_reset();

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // state right after reset, cpu_en still low
        check_pc(RESET_PC, instr_addr);
        for (int r = 0; r < 8; r++) begin
            reg_addr = reg_addr_t'(r);
            #1;
            check_reg(reg_addr, '0, reg_data);
        end

        @(posedge clk);
        #1;
        drive_next();
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #1;
            check_pc(model_pc, instr_addr);                     // every cycle, held or not
            check_reg(reg_addr, model_regs[reg_addr], reg_data);
            drive_next();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : cpu_tb

// ==== sim.f ====
+incdir+verif
source/cpu_pkg.sv
source/cpu_pc_unit.sv
source/cpu_reg_file.sv
source/cpu_alu.sv
source/cpu_imm_gen.sv
source/cpu_decoder.sv
source/cpu_core.sv
verif/cpu_tb.sv
